// ==== common/mxu_pkg.sv ====
`default_nettype none

package mxu_pkg;

        ////////////////////
        // Array geometry
        ////////////////////
        localparam int ROWS = 4;
        localparam int COLUMNS = 4;
        localparam int DATA_WIDTH = 8;
        // Four 16-bit products plus headroom for the adds
        localparam int ACC_WIDTH = 20;

        // Memory and queue sizes
        localparam int CSR_DEPTH = 4;
        localparam int FIFO_DEPTH = 8;
        localparam int CSR_ADDR_WIDTH = $clog2(CSR_DEPTH);
        localparam int ROW_INDEX_WIDTH = $clog2(ROWS);

        ////////////////////
        // Data types
        ////////////////////
        typedef logic signed [DATA_WIDTH-1:0] element_t;
        typedef logic signed [ACC_WIDTH-1:0] acc_t;

        // Input vector, or weight row r holding w[r][0..COLUMNS-1]
        typedef struct packed {
                element_t [ROWS-1:0] e;
        } vector_t;

        // One output vector, column sums
        typedef struct packed {
                acc_t [COLUMNS-1:0] y;
        } result_t;

        // Byte 0 is the vector count
        typedef logic [7:0] csr_byte_t;

        // Sequencer states
        typedef enum logic [2:0] {
                IDLE,
                READ_CSR,
                LOAD_WEIGHTS,
                COMPUTE,
                DRAIN,
                DONE
        } cu_state_t;

endpackage

`default_nettype wire

// ==== rtl/block_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module block_ram #(
        parameter type word_t = logic [7:0],
        parameter int DEPTH = 4
) (
        input wire logic clk,
        // Host write port
        input wire logic load,
        input wire logic [$clog2(DEPTH)-1:0] load_address,
        input wire word_t load_data,
        // Registered read port
        input wire logic ce,
        input wire logic [$clog2(DEPTH)-1:0] address,
        output word_t dout
);

        // Storage only
        word_t mem [DEPTH];

        always_ff @(posedge clk) begin
                if (load) begin
                        mem[load_address] <= load_data;
                end
                // Same-address write in this cycle is not yet visible
                if (ce) begin
                        dout <= mem[address];
                end
        end

endmodule

`default_nettype wire

// ==== rtl/sync_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
        parameter type payload_t = logic [7:0],
        parameter int DEPTH = 8
) (
        input wire logic clk,
        input wire logic reset,
        input wire logic write,
        input wire payload_t write_data,
        input wire logic read,
        output payload_t read_data,
        output logic full,
        output logic empty
);

        payload_t buffer [DEPTH];
        logic [$clog2(DEPTH)-1:0] wr_ptr;
        logic [$clog2(DEPTH)-1:0] rd_ptr;
        logic [$clog2(DEPTH+1)-1:0] count;
        logic accept_write;
        logic accept_read;

        // Levels straight from occupancy
        assign full = (count == DEPTH);
        assign empty = (count == 0);

        // Overflow and underflow attempts dropped
        assign accept_write = write && !full;
        assign accept_read = read && !empty;

        // Pointers and occupancy
        always_ff @(posedge clk) begin
                if (reset) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count <= '0;
                end else begin
                        if (accept_write) begin
                                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
                        end
                        if (accept_read) begin
                                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
                        end
                        case ({accept_write, accept_read})
                                2'b10: count <= count + 1'b1;
                                2'b01: count <= count - 1'b1;
                                default: count <= count;
                        endcase
                end
        end

        // Buffer and output word
        always_ff @(posedge clk) begin
                if (accept_write) begin
                        buffer[wr_ptr] <= write_data;
                end
                // Held until the next accepted read
                if (accept_read) begin
                        read_data <= buffer[rd_ptr];
                end
        end

endmodule

`default_nettype wire

// ==== rtl/control_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module control_unit (
        input wire logic clk,
        input wire logic reset,
        input wire logic glb_enable,
        // Host control strobes
        input wire logic cs_start,
        input wire logic cs_continue,
        output logic cs_ready,
        output logic cs_idle,
        output logic cs_done,
        // CSR memory read port
        output logic csr_ce,
        output logic [mxu_pkg::CSR_ADDR_WIDTH-1:0] csr_address,
        input wire mxu_pkg::csr_byte_t csr_dout,
        // Weight memory read port
        output logic wm_ce,
        output logic [mxu_pkg::ROW_INDEX_WIDTH-1:0] wm_address,
        input wire mxu_pkg::vector_t wm_dout,
        // Row delivery to the array
        output logic weight_load,
        output logic [mxu_pkg::ROW_INDEX_WIDTH-1:0] weight_row,
        output mxu_pkg::vector_t weight_data,
        // FIFO levels, strobes and pipeline control
        input wire logic infifo_is_empty,
        input wire logic outfifo_is_full,
        output logic infifo_read,
        output logic outfifo_write,
        output logic x_valid,
        output logic enable_mxu,
        input wire logic result_valid
);

        mxu_pkg::cu_state_t state;
        mxu_pkg::cu_state_t state_next;
        mxu_pkg::csr_byte_t vector_count;
        logic [7:0] reads_issued;
        logic [7:0] results_written;
        logic [mxu_pkg::ROW_INDEX_WIDTH:0] issue_row;
        logic wm_pending;
        logic [mxu_pkg::ROW_INDEX_WIDTH-1:0] wm_pending_row;
        logic load_complete;
        logic streaming;

        ////////////////////
        // Strobes
        ////////////////////
        assign cs_idle = (state == mxu_pkg::IDLE);
        assign cs_ready = (state == mxu_pkg::IDLE);

        // Count byte read as start is taken
        assign csr_address = '0;
        assign csr_ce = cs_ready && cs_start && glb_enable;

        // One row read per cycle until all issued
        assign wm_ce = (state == mxu_pkg::LOAD_WEIGHTS) && glb_enable
                && (issue_row < mxu_pkg::ROWS);
        assign wm_address = issue_row[mxu_pkg::ROW_INDEX_WIDTH-1:0];
        // All reads issued and the two-stage row path empty
        assign load_complete = (issue_row == mxu_pkg::ROWS) && !wm_pending && !weight_load;

        // Single stall point for the whole array
        assign streaming = (state == mxu_pkg::COMPUTE) || (state == mxu_pkg::DRAIN);
        assign enable_mxu = streaming && glb_enable && !outfifo_is_full;
        // Empty input only leaves a bubble
        assign infifo_read = enable_mxu && (state == mxu_pkg::COMPUTE) && !infifo_is_empty
                && (reads_issued != vector_count);
        assign outfifo_write = result_valid && enable_mxu;

        ////////////////////
        // Next state
        ////////////////////
        always_comb begin
                state_next = state;
                case (state)
                        mxu_pkg::IDLE: begin
                                if (cs_start) state_next = mxu_pkg::READ_CSR;
                        end
                        mxu_pkg::READ_CSR: begin
                                // Zero count skips the whole run
                                if (csr_dout == 0) state_next = mxu_pkg::DONE;
                                else state_next = mxu_pkg::LOAD_WEIGHTS;
                        end
                        mxu_pkg::LOAD_WEIGHTS: begin
                                if (load_complete) state_next = mxu_pkg::COMPUTE;
                        end
                        mxu_pkg::COMPUTE: begin
                                if (reads_issued == vector_count) state_next = mxu_pkg::DRAIN;
                        end
                        mxu_pkg::DRAIN: begin
                                if (results_written == vector_count) state_next = mxu_pkg::DONE;
                        end
                        mxu_pkg::DONE: begin
                                if (cs_continue) state_next = mxu_pkg::IDLE;
                        end
                        default: state_next = mxu_pkg::IDLE;
                endcase
                // Global enable freezes the sequencer
                if (!glb_enable) state_next = state;
        end

        ////////////////////
        // State and counters
        ////////////////////
        always_ff @(posedge clk) begin
                if (reset) begin
                        state <= mxu_pkg::IDLE;
                        cs_done <= 1'b0;
                        vector_count <= '0;
                        reads_issued <= '0;
                        results_written <= '0;
                        issue_row <= '0;
                        wm_pending <= 1'b0;
                        wm_pending_row <= '0;
                        weight_load <= 1'b0;
                        weight_row <= '0;
                        x_valid <= 1'b0;
                end else begin
                        state <= state_next;
                        // Pulse on the first DONE cycle
                        cs_done <= (state_next == mxu_pkg::DONE) && (state != mxu_pkg::DONE);
                        if (state == mxu_pkg::READ_CSR) vector_count <= csr_dout;
                        // Fresh run
                        if (csr_ce) begin
                                reads_issued <= '0;
                                results_written <= '0;
                                issue_row <= '0;
                        end
                        if (wm_ce) issue_row <= issue_row + 1'b1;
                        if (infifo_read) reads_issued <= reads_issued + 1'b1;
                        if (outfifo_write) results_written <= results_written + 1'b1;
                        // RAM latency, then the registered row
                        wm_pending <= wm_ce;
                        wm_pending_row <= wm_address;
                        weight_load <= wm_pending;
                        weight_row <= wm_pending_row;
                        // FIFO word valid one cycle after the read, held on stall
                        if (enable_mxu) x_valid <= infifo_read;
                end
        end

        // Row payload
        always_ff @(posedge clk) begin
                if (wm_pending) weight_data <= wm_dout;
        end

endmodule

`default_nettype wire

// ==== mxu/mxu_array.sv ====
`timescale 1ns/100ps
`default_nettype none

module mxu_array (
        input wire logic clk,
        input wire logic reset,
        input wire logic enable_mxu,
        input wire logic weight_load,
        input wire logic [mxu_pkg::ROW_INDEX_WIDTH-1:0] weight_row,
        input wire mxu_pkg::vector_t weight_data,
        input wire logic x_valid,
        input wire mxu_pkg::vector_t x_data,
        output logic result_valid,
        output mxu_pkg::result_t result_data
);

        // Stationary weights, one row per stage
        mxu_pkg::vector_t weights [mxu_pkg::ROWS];
        // Input copies travelling with the partial sums
        mxu_pkg::vector_t x_delay [mxu_pkg::ROWS-1];
        mxu_pkg::acc_t psum [mxu_pkg::ROWS][mxu_pkg::COLUMNS];
        logic [mxu_pkg::ROWS-1:0] stage_valid;

        // Sign-extend first, product fits the accumulator
        function automatic mxu_pkg::acc_t product(input mxu_pkg::element_t a,
                                                  input mxu_pkg::element_t b);
                product = mxu_pkg::acc_t'(a) * mxu_pkg::acc_t'(b);
        endfunction

        // Loaded while the pipeline is idle
        always_ff @(posedge clk) begin
                if (weight_load) weights[weight_row] <= weight_data;
        end

        // Valid bits move with the data
        always_ff @(posedge clk) begin
                if (reset) begin
                        stage_valid <= '0;
                end else if (enable_mxu) begin
                        stage_valid <= {stage_valid[mxu_pkg::ROWS-2:0], x_valid};
                end
        end

        ////////////////////
        // Multiply-add stages
        ////////////////////
        always_ff @(posedge clk) begin
                if (enable_mxu) begin
                        // Stage 0 takes x[0] straight from the FIFO
                        x_delay[0] <= x_data;
                        for (int c = 0; c < mxu_pkg::COLUMNS; c++) begin
                                psum[0][c] <= product(x_data.e[0], weights[0].e[c]);
                        end
                        for (int r = 1; r < mxu_pkg::ROWS - 1; r++) begin
                                x_delay[r] <= x_delay[r-1];
                        end
                        // Stage r sees x[r] r cycles late
                        for (int r = 1; r < mxu_pkg::ROWS; r++) begin
                                for (int c = 0; c < mxu_pkg::COLUMNS; c++) begin
                                        psum[r][c] <= psum[r-1][c]
                                                + product(x_delay[r-1].e[r], weights[r].e[c]);
                                end
                        end
                end
        end

        // Last stage is the result
        always_comb begin
                for (int c = 0; c < mxu_pkg::COLUMNS; c++) begin
                        result_data.y[c] = psum[mxu_pkg::ROWS-1][c];
                end
        end
        assign result_valid = stage_valid[mxu_pkg::ROWS-1];

endmodule

`default_nettype wire

// ==== mxu/mxu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module mxu_top (
        input wire logic clk,
        input wire logic reset,
        // Configuration bytes
        input wire logic csr_load,
        input wire logic [mxu_pkg::CSR_ADDR_WIDTH-1:0] csr_load_address,
        input wire mxu_pkg::csr_byte_t csr_load_data,
        // Weight rows
        input wire logic wm_load,
        input wire logic [mxu_pkg::ROW_INDEX_WIDTH-1:0] wm_load_address,
        input wire mxu_pkg::vector_t wm_load_data,
        // Input vector stream
        input wire logic in_push,
        input wire mxu_pkg::vector_t in_data,
        output logic in_full,
        // Result stream
        input wire logic out_pop,
        output mxu_pkg::result_t out_data,
        output logic out_empty,
        // Host control
        input wire logic cs_start,
        input wire logic cs_continue,
        input wire logic glb_enable,
        output logic cs_ready,
        output logic cs_idle,
        output logic cs_done
);

        logic csr_ce;
        logic [mxu_pkg::CSR_ADDR_WIDTH-1:0] csr_address;
        mxu_pkg::csr_byte_t csr_dout;
        logic wm_ce;
        logic [mxu_pkg::ROW_INDEX_WIDTH-1:0] wm_address;
        mxu_pkg::vector_t wm_dout;
        logic weight_load;
        logic [mxu_pkg::ROW_INDEX_WIDTH-1:0] weight_row;
        mxu_pkg::vector_t weight_data;
        logic infifo_read;
        logic infifo_is_empty;
        mxu_pkg::vector_t x_data;
        logic x_valid;
        logic outfifo_write;
        logic outfifo_is_full;
        logic enable_mxu;
        logic result_valid;
        mxu_pkg::result_t result_data;

        ////////////////////
        // Memories
        ////////////////////
        block_ram #(
                .word_t(mxu_pkg::csr_byte_t),
                .DEPTH(mxu_pkg::CSR_DEPTH)
        ) csr_ram (
                .clk(clk),
                .load(csr_load),
                .load_address(csr_load_address),
                .load_data(csr_load_data),
                .ce(csr_ce),
                .address(csr_address),
                .dout(csr_dout)
        );

        block_ram #(
                .word_t(mxu_pkg::vector_t),
                .DEPTH(mxu_pkg::ROWS)
        ) weight_ram (
                .clk(clk),
                .load(wm_load),
                .load_address(wm_load_address),
                .load_data(wm_load_data),
                .ce(wm_ce),
                .address(wm_address),
                .dout(wm_dout)
        );

        ////////////////////
        // Stream FIFOs
        ////////////////////
        sync_fifo #(
                .payload_t(mxu_pkg::vector_t),
                .DEPTH(mxu_pkg::FIFO_DEPTH)
        ) in_fifo (
                .clk(clk),
                .reset(reset),
                .write(in_push),
                .write_data(in_data),
                .read(infifo_read),
                .read_data(x_data),
                .full(in_full),
                .empty(infifo_is_empty)
        );

        sync_fifo #(
                .payload_t(mxu_pkg::result_t),
                .DEPTH(mxu_pkg::FIFO_DEPTH)
        ) out_fifo (
                .clk(clk),
                .reset(reset),
                .write(outfifo_write),
                .write_data(result_data),
                .read(out_pop),
                .read_data(out_data),
                .full(outfifo_is_full),
                .empty(out_empty)
        );

        ////////////////////
        // Sequencer and array
        ////////////////////
        control_unit cu (
                .clk(clk),
                .reset(reset),
                .glb_enable(glb_enable),
                .cs_start(cs_start),
                .cs_continue(cs_continue),
                .cs_ready(cs_ready),
                .cs_idle(cs_idle),
                .cs_done(cs_done),
                .csr_ce(csr_ce),
                .csr_address(csr_address),
                .csr_dout(csr_dout),
                .wm_ce(wm_ce),
                .wm_address(wm_address),
                .wm_dout(wm_dout),
                .weight_load(weight_load),
                .weight_row(weight_row),
                .weight_data(weight_data),
                .infifo_is_empty(infifo_is_empty),
                .outfifo_is_full(outfifo_is_full),
                .infifo_read(infifo_read),
                .outfifo_write(outfifo_write),
                .x_valid(x_valid),
                .enable_mxu(enable_mxu),
                .result_valid(result_valid)
        );

        mxu_array array (
                .clk(clk),
                .reset(reset),
                .enable_mxu(enable_mxu),
                .weight_load(weight_load),
                .weight_row(weight_row),
                .weight_data(weight_data),
                .x_valid(x_valid),
                .x_data(x_data),
                .result_valid(result_valid),
                .result_data(result_data)
        );

endmodule

`default_nettype wire

// ==== test/tb_mxu_model.svh ====
`ifndef TB_MXU_MODEL_SVH
`define TB_MXU_MODEL_SVH

////////////////////
// Random source
////////////////////
localparam logic [15:0] LFSR_SEED = 16'd6324;
// x^16 + x^14 + x^13 + x^11 + 1
localparam logic [15:0] LFSR_TAPS = 16'hB400;

logic [15:0] lfsr_state = LFSR_SEED;

function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
endfunction

// One step per bit, first bit taken ends up highest
function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
                bits = {bits[30:0], lfsr_state[0]};
                lfsr_state = lfsr_step(lfsr_state);
        end
        return bits;
endfunction

function automatic mxu_pkg::vector_t random_vector();
        mxu_pkg::vector_t v;
        for (int i = 0; i < mxu_pkg::ROWS; i++) begin
                v.e[i] = mxu_pkg::element_t'(take_bits(mxu_pkg::DATA_WIDTH));
        end
        return v;
endfunction

////////////////////
// Reference model
////////////////////
// Row r holds w[r][0..COLUMNS-1]
mxu_pkg::vector_t model_weights [mxu_pkg::ROWS];
// Expected results in input order
mxu_pkg::result_t expected_q [$];

// y[c] = sum over r of x[r] * w[r][c]
function automatic mxu_pkg::result_t model_result(input mxu_pkg::vector_t x);
        mxu_pkg::result_t y;
        int sum;
        for (int c = 0; c < mxu_pkg::COLUMNS; c++) begin
                sum = 0;
                for (int r = 0; r < mxu_pkg::ROWS; r++) begin
                        sum += int'($signed(x.e[r])) * int'($signed(model_weights[r].e[c]));
                end
                y.y[c] = sum[mxu_pkg::ACC_WIDTH-1:0];
        end
        return y;
endfunction

`endif

// ==== test/tb_mxu.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_mxu;

        `include "tb_mxu_model.svh"

        localparam int CLOCK_PERIOD = 8;
        localparam int DRIVE_DELAY = 1;
        localparam int RESET_CYCLES = 16;
        // Vectors per run
        localparam int BASIC_COUNT = 6;
        localparam int STARVE_COUNT = 12;
        localparam int BLOCKED_COUNT = 24;
        localparam int ENABLE_COUNT = 10;
        localparam int REUSE_COUNT = 5;
        localparam int RUN_COUNT = 6;
        localparam int TOTAL_VECTORS = BASIC_COUNT + STARVE_COUNT + BLOCKED_COUNT
                + ENABLE_COUNT + REUSE_COUNT;
        localparam int CYCLE_LIMIT = 20 * TOTAL_VECTORS + 200 * RUN_COUNT;
        // Cycles with results waiting before pops begin
        localparam int POP_HOLD = 30;
        localparam int DONE_WAIT = 6;
        // Pop policies
        localparam int POP_FREE = 0;
        localparam int POP_HELD = 1;

        logic clk = 1'b0;
        logic reset;
        logic csr_load;
        logic [mxu_pkg::CSR_ADDR_WIDTH-1:0] csr_load_address;
        mxu_pkg::csr_byte_t csr_load_data;
        logic wm_load;
        logic [mxu_pkg::ROW_INDEX_WIDTH-1:0] wm_load_address;
        mxu_pkg::vector_t wm_load_data;
        logic in_push;
        mxu_pkg::vector_t in_data;
        logic in_full;
        logic out_pop;
        mxu_pkg::result_t out_data;
        logic out_empty;
        logic cs_start;
        logic cs_continue;
        logic glb_enable;
        logic cs_ready;
        logic cs_idle;
        logic cs_done;

        // Run bookkeeping
        string test_name = "reset";
        int cycle_count = 0;
        int data_errors = 0;
        int control_errors = 0;
        int results_checked = 0;
        int results_run;
        int done_run;
        int pop_mode;
        int hold_cycles;
        int drop_left;
        logic enable_jitter;
        logic pop_pending;
        logic full_seen;

        mxu_top dut0 (
                .clk(clk),
                .reset(reset),
                .csr_load(csr_load),
                .csr_load_address(csr_load_address),
                .csr_load_data(csr_load_data),
                .wm_load(wm_load),
                .wm_load_address(wm_load_address),
                .wm_load_data(wm_load_data),
                .in_push(in_push),
                .in_data(in_data),
                .in_full(in_full),
                .out_pop(out_pop),
                .out_data(out_data),
                .out_empty(out_empty),
                .cs_start(cs_start),
                .cs_continue(cs_continue),
                .glb_enable(glb_enable),
                .cs_ready(cs_ready),
                .cs_idle(cs_idle),
                .cs_done(cs_done)
        );

        always #(CLOCK_PERIOD / 2) clk = ~clk;

        // Run length guard
        always @(posedge clk) begin
                cycle_count++;
                if (cycle_count >= CYCLE_LIMIT) begin
                        $display("timeout: test %s still running after %0d cycles",
                                test_name, cycle_count);
                        $display("errors: %0d data, %0d control, %0d results checked",
                                data_errors, control_errors, results_checked);
                        $display("Verification failed");
                        $finish;
                end
        end

        task automatic report_failure(input string what);
                control_errors++;
                $display("error %s: %s", test_name, what);
        endtask

        ////////////////////
        // Per-cycle sampling
        ////////////////////
        task automatic check_outputs();
                mxu_pkg::result_t want;
                // Word popped on the last edge
                if (pop_pending) begin
                        results_run++;
                        results_checked++;
                        if (expected_q.size() == 0) begin
                                report_failure("result popped with no input vector behind it");
                        end else begin
                                want = expected_q.pop_front();
                                if (out_data !== want) begin
                                        data_errors++;
                                        $display("error %s: result %0d expected %h actual %h",
                                                test_name, results_run, want, out_data);
                                end
                        end
                end
                if (cs_done) begin
                        done_run++;
                        // Level that was applied at the edge which raised cs_done
                        if (!glb_enable) report_failure("cs_done pulsed while glb_enable was low");
                end
                if (in_full) full_seen = 1'b1;
        endtask

        task automatic drive_pop();
                if (out_empty) begin
                        out_pop = 1'b0;
                end else if (pop_mode == POP_FREE) begin
                        out_pop = 1'b1;
                end else if (hold_cycles < POP_HOLD) begin
                        hold_cycles++;
                        out_pop = 1'b0;
                end else begin
                        out_pop = (take_bits(1) != 0);
                end
                // Empty level cannot change before the next edge
                pop_pending = out_pop && !out_empty;
        endtask

        // Random drops of a few cycles
        task automatic drive_enable();
                if (!enable_jitter) begin
                        glb_enable = 1'b1;
                end else if (drop_left > 0) begin
                        glb_enable = 1'b0;
                        drop_left--;
                end else begin
                        glb_enable = 1'b1;
                        if (take_bits(3) == 0) drop_left = 2 + int'(take_bits(2));
                end
        endtask

        task automatic next_cycle();
                @(posedge clk);
                #DRIVE_DELAY;
                check_outputs();
                // One-cycle strobes
                csr_load = 1'b0;
                wm_load = 1'b0;
                in_push = 1'b0;
                drive_pop();
                drive_enable();
        endtask

        ////////////////////
        // Run steps
        ////////////////////
        task automatic prepare_run(input string name, input int count, input bit new_weights);
                mxu_pkg::vector_t row;
                test_name = name;
                results_run = 0;
                done_run = 0;
                full_seen = 1'b0;
                hold_cycles = 0;
                if (new_weights) begin
                        for (int r = 0; r < mxu_pkg::ROWS; r++) begin
                                row = random_vector();
                                model_weights[r] = row;
                                wm_load = 1'b1;
                                wm_load_address = r[mxu_pkg::ROW_INDEX_WIDTH-1:0];
                                wm_load_data = row;
                                next_cycle();
                        end
                end
                // Vector count in CSR byte 0
                csr_load = 1'b1;
                csr_load_address = '0;
                csr_load_data = mxu_pkg::csr_byte_t'(count);
                next_cycle();
        endtask

        task automatic push_vector(input int gap);
                mxu_pkg::vector_t v;
                repeat (gap) next_cycle();
                // Push only into room so every push is taken
                while (in_full) next_cycle();
                v = random_vector();
                expected_q.push_back(model_result(v));
                in_push = 1'b1;
                in_data = v;
                next_cycle();
        endtask

        task automatic start_run();
                cs_start = 1'b1;
                next_cycle();
                // Held until taken
                while (cs_idle) next_cycle();
                cs_start = 1'b0;
        endtask

        task automatic finish_run(input int count);
                while (done_run == 0 || results_run < count) next_cycle();
                enable_jitter = 1'b0;
                pop_mode = POP_FREE;
                // DONE holds without continue and gives no late results
                repeat (DONE_WAIT) begin
                        next_cycle();
                        if (cs_idle) report_failure("cs_idle rose before cs_continue");
                end
                if (done_run != 1) begin
                        report_failure($sformatf("cs_done pulses expected 1 actual %0d", done_run));
                end
                if (results_run != count) begin
                        report_failure($sformatf("result count expected %0d actual %0d",
                                count, results_run));
                end
                if (!out_empty) report_failure("output FIFO still holds results after the run");
                cs_continue = 1'b1;
                next_cycle();
                while (!cs_idle) next_cycle();
                cs_continue = 1'b0;
                if (!cs_ready) report_failure("cs_ready low after return to idle");
        endtask

        ////////////////////
        // Test sequence
        ////////////////////
        initial begin
                reset = 1'b1;
                csr_load = 1'b0;
                csr_load_address = '0;
                csr_load_data = '0;
                wm_load = 1'b0;
                wm_load_address = '0;
                wm_load_data = '0;
                in_push = 1'b0;
                in_data = '0;
                out_pop = 1'b0;
                cs_start = 1'b0;
                cs_continue = 1'b0;
                glb_enable = 1'b1;
                enable_jitter = 1'b0;
                pop_mode = POP_FREE;
                pop_pending = 1'b0;
                drop_left = 0;
                results_run = 0;
                done_run = 0;
                hold_cycles = 0;
                full_seen = 1'b0;
                repeat (RESET_CYCLES) @(posedge clk);
                #DRIVE_DELAY;
                reset = 1'b0;

                // Idle and ready with no done and nothing queued
                if ({cs_idle, cs_ready, cs_done, out_empty} !== 4'b1101) begin
                        report_failure($sformatf(
                                "idle/ready/done/empty expected 1101 actual %b%b%b%b",
                                cs_idle, cs_ready, cs_done, out_empty));
                end

                // Whole batch waiting before start
                prepare_run("basic", BASIC_COUNT, 1'b1);
                repeat (BASIC_COUNT) push_vector(0);
                start_run();
                finish_run(BASIC_COUNT);

                // Slow producer leaves bubbles
                prepare_run("starve", STARVE_COUNT, 1'b1);
                start_run();
                repeat (STARVE_COUNT) push_vector(int'(take_bits(3)));
                finish_run(STARVE_COUNT);

                // Consumer blocked until both FIFOs fill
                prepare_run("backpressure", BLOCKED_COUNT, 1'b1);
                pop_mode = POP_HELD;
                start_run();
                repeat (BLOCKED_COUNT) push_vector(0);
                finish_run(BLOCKED_COUNT);
                if (!full_seen) report_failure("in_full never rose while results were blocked");

                // Global enable dropping
                prepare_run("enable", ENABLE_COUNT, 1'b1);
                enable_jitter = 1'b1;
                start_run();
                repeat (ENABLE_COUNT) push_vector(int'(take_bits(2)));
                finish_run(ENABLE_COUNT);

                // Empty run then reuse of the stored weights
                prepare_run("reuse_zero", 0, 1'b1);
                start_run();
                finish_run(0);
                prepare_run("reuse_five", REUSE_COUNT, 1'b0);
                start_run();
                repeat (REUSE_COUNT) push_vector(int'(take_bits(2)));
                finish_run(REUSE_COUNT);

                $display("errors: %0d data, %0d control, %0d results checked",
                        data_errors, control_errors, results_checked);
                if (data_errors == 0 && control_errors == 0) begin
                        $display("Verification passed");
                end else begin
                        $display("Verification failed");
                end
                $finish;
        end

endmodule

`default_nettype wire

// ==== mxu.f ====
+incdir+test
common/mxu_pkg.sv
rtl/block_ram.sv
rtl/sync_fifo.sv
rtl/control_unit.sv
mxu/mxu_array.sv
mxu/mxu_top.sv
test/tb_mxu.sv
